//--- dv/dispatch_tests.txt
# P op pc imm rd rs1 rs2 : push a micro-op (hex fields, op is the uop_e code)
# A/B/L/C op pc imm rd_tag rs1_tag rs2_tag : pop alu/bru/lsu/csr head, expected record
# R pc rd_tag : commit the reorder head | W n : idle cycles | F n : uop_full level | E : all empty
# Routing of every class, x0 sources, dropped mret and ebreak
P 02 1000 10 01 00 00
P 04 1004 0 02 01 01
P 1e 1008 20 00 00 00
P 20 100c 40 00 01 02
P 28 1010 8 03 02 00
P 2f 1014 c 00 03 01
P 33 1018 12345abc 05 01 00
P 39 101c 0 04 00 00
P 3a 1020 0 04 00 00
P 02 1024 1 01 01 00
A 02 1000 10 05 00 00
A 04 1004 0 09 05 05
A 02 1024 1 06 05 00
B 1e 1008 20 00 00 00
B 20 100c 40 00 05 09
L 28 1010 8 0d 09 00
L 2f 1014 c 00 0d 05
C 33 1018 12345abc 15 05 00
R 1000 05
R 1004 09
R 1008 00
R 100c 00
R 1010 0d
R 1014 00
R 1018 15
R 1024 06
E
# Copies 1 to 3 of x6, then a fourth write runs out and blocks the queue
P 02 2000 1 06 06 00
P 02 2004 2 06 06 00
P 02 2008 3 06 06 00
P 04 200c 0 06 06 06
P 2f 2010 0 00 06 01
P 2f 2014 4 00 06 01
P 2f 2018 8 00 00 06
P 20 201c 10 00 06 06
P 20 2020 14 00 01 00
P 20 2024 18 00 00 00
P 31 2028 0 00 00 00
W 3
F 1
R 2000 19
W 2
F 0
A 02 2000 1 19 18 00
A 02 2004 2 1a 19 00
A 02 2008 3 1b 1a 00
A 04 200c 0 18 1b 1b
R 2004 1a
R 2008 1b
R 200c 18
L 2f 2010 0 00 18 06
L 2f 2014 4 00 18 06
L 2f 2018 8 00 00 18
B 20 201c 10 00 18 18
B 20 2020 14 00 06 00
B 20 2024 18 00 00 00
L 31 2028 0 00 00 00
R 2010 00
R 2014 00
R 2018 00
R 201c 00
R 2020 00
R 2024 00
R 2028 00
E
# Full load/store queue stalls the loads and the ALU op behind them
P 28 3000 0 07 00 00
P 28 3004 0 08 00 00
P 28 3008 0 09 00 00
P 28 300c 0 0a 00 00
P 28 3010 0 0b 00 00
P 02 3014 5 0c 07 00
W 4
L 28 3000 0 1d 00 00
L 28 3004 0 21 00 00
L 28 3008 0 25 00 00
L 28 300c 0 29 00 00
L 28 3010 0 2d 00 00
A 02 3014 5 31 1d 00
R 3000 1d
R 3004 21
R 3008 25
R 300c 29
R 3010 2d
R 3014 31
E

//--- compile.f
rtl/dispatch_pkg.sv
rtl/sync_fifo.sv
rtl/rename_state.sv
rtl/rename.sv
rtl/dispatch.sv
rtl/dispatch_top.sv
dv/dispatch_tb.sv

//--- Makefile
SIM := obj_dir/Vdispatch_tb
SRCS := $(wildcard rtl/*.sv) dv/dispatch_tb.sv

.PHONY: all run clean

all: run

$(SIM): $(SRCS) compile.f
	verilator --binary --timing --top-module dispatch_tb -f compile.f -o Vdispatch_tb

run: $(SIM) dv/dispatch_tests.txt
	-./$(SIM) > sim.log 2>&1
	cat sim.log
	! grep -q "TEST RESULT: FAIL" sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/dispatch_tb.sv
// Testbench for the dispatch stage. Runs the command file in dv/ and checks
// every popped record against a reference rename model.
`timescale 1ns/1ps

module dispatch_tb;

	import dispatch_pkg::*;

	localparam int rec_w = alu_info_w;

	logic CLK = 1'b0;
	logic reset = 1'b1;
	logic uop_push = 1'b0;
	logic [uop_w-1:0] uop = '0;
	logic uop_full;
	logic alu_valid, bru_valid, lsu_valid, csr_valid, rob_valid;
	logic [alu_info_w-1:0] alu_info;
	logic [bru_info_w-1:0] bru_info;
	logic [lsu_info_w-1:0] lsu_info;
	logic [csr_info_w-1:0] csr_info;
	logic [rob_info_w-1:0] rob_info;
	logic alu_pop = 1'b0;
	logic bru_pop = 1'b0;
	logic lsu_pop = 1'b0;
	logic csr_pop = 1'b0;
	logic rob_pop = 1'b0;

	// Reference rename state.
	logic [rb-1:0] used [areg_n];
	logic [rb_w-1:0] active [areg_n];
	logic [rb_w-1:0] arch [areg_n];
	logic [uop_w-1:0] pend [$];
	logic [rec_w-1:0] exp_alu [$];
	logic [rec_w-1:0] exp_bru [$];
	logic [rec_w-1:0] exp_lsu [$];
	logic [rec_w-1:0] exp_csr [$];
	logic [rob_info_w-1:0] exp_rob [$];
	string lines [$];
	int limit_cycles = 0;

	dispatch_top DUT (
		.CLK(CLK), .reset(reset), .uop_push(uop_push), .uop(uop), .uop_full(uop_full),
		.alu_valid(alu_valid), .alu_info(alu_info), .alu_pop(alu_pop),
		.bru_valid(bru_valid), .bru_info(bru_info), .bru_pop(bru_pop),
		.lsu_valid(lsu_valid), .lsu_info(lsu_info), .lsu_pop(lsu_pop),
		.csr_valid(csr_valid), .csr_info(csr_info), .csr_pop(csr_pop),
		.rob_valid(rob_valid), .rob_info(rob_info), .rob_pop(rob_pop));

	always #4 CLK = ~CLK;

	task automatic fail_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [rec_w-1:0] got,
			input logic [rec_w-1:0] exp);
		assert (got === exp) else begin
			$display("FAIL %s: got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic step();
		@(posedge CLK);
		#1;
	endtask

	// Issue class: 0 alu, 1 branch, 2 load/store, 3 csr, 4 dropped.
	function automatic int class_of(input logic [op_w-1:0] op);
		if (op <= op_sraw)
			return 0;
		if (op <= op_bgeu)
			return 1;
		if (op <= op_fence_i)
			return 2;
		if (op <= op_csrrci)
			return 3;
		return 4;
	endfunction

	function automatic bit writes_rd(input logic [op_w-1:0] op);
		int cls;
		cls = class_of(op);
		return cls == 0 || cls == 3 || op == op_jal || op == op_jalr
			|| (op >= op_lb && op <= op_lwu);
	endfunction

	function automatic logic [rec_w-1:0] make_record(input int cls, input logic [op_w-1:0] op,
			input logic [xlen_w-1:0] pc, input logic [xlen_w-1:0] imm,
			input logic [tag_w-1:0] rdt, input logic [tag_w-1:0] r1t,
			input logic [tag_w-1:0] r2t);
		if (cls == 2)
			return rec_w'({op, imm, rdt, r1t, r2t});
		if (cls == 3)
			return rec_w'({op, pc, imm[11:0], rdt, r1t});
		return {op, pc, imm, rdt, r1t, r2t};
	endfunction

	// Renames one micro-op in program order. Returns 0 when rd has no free copy.
	function automatic bit rename_one(input logic [uop_w-1:0] u);
		logic [op_w-1:0] op;
		logic [xlen_w-1:0] pc, imm;
		logic [areg_w-1:0] rd, rs1, rs2;
		logic [tag_w-1:0] rdt, r1t, r2t;
		logic [rb_w-1:0] idx;
		logic [rec_w-1:0] rec;
		int cls;
		{op, pc, imm, rd, rs1, rs2} = u;
		cls = class_of(op);
		if (cls == 4)
			return 1;
		if (!writes_rd(op))
			rd = '0;
		if (rd != 0 && used[rd] == '1)
			return 0;
		r1t = {rs1, active[rs1]};
		r2t = {rs2, active[rs2]};
		rdt = '0;
		if (rd != 0) begin
			idx = '0;
			for (int i = rb - 1; i >= 0; i--)
				if (!used[rd][i])
					idx = rb_w'(i);
			used[rd][idx] = 1'b1;
			active[rd] = idx;
			rdt = {rd, idx};
		end
		rec = make_record(cls, op, pc, imm, rdt, r1t, r2t);
		case (cls)
			0: exp_alu.push_back(rec);
			1: exp_bru.push_back(rec);
			2: exp_lsu.push_back(rec);
			default: exp_csr.push_back(rec);
		endcase
		exp_rob.push_back({pc, rdt, rd != 0, op >= op_beq && op <= op_bgeu,
			op >= op_sb && op <= op_sd, cls == 3});
		return 1;
	endfunction

	function automatic void drain();
		while (pend.size() > 0 && rename_one(pend[0]))
			void'(pend.pop_front());
	endfunction

	task automatic push_uop(input logic [31:0] f [6]);
		while (uop_full)
			step();
		uop = {f[0][op_w-1:0], f[1], f[2], f[3][areg_w-1:0], f[4][areg_w-1:0],
			f[5][areg_w-1:0]};
		uop_push = 1'b1;
		pend.push_back(uop);
		drain();
		step();
		uop_push = 1'b0;
	endtask

	task automatic pop_queue(input int cls, input logic [31:0] f [6]);
		logic [rec_w-1:0] model;
		logic [rec_w-1:0] got;
		logic ok;
		string name;
		ok = 1'b0;
		while (!ok) begin
			ok = (cls == 0) ? alu_valid : (cls == 1) ? bru_valid
				: (cls == 2) ? lsu_valid : csr_valid;
			if (!ok)
				step();
		end
		ok = (cls == 0) ? exp_alu.size() > 0 : (cls == 1) ? exp_bru.size() > 0
			: (cls == 2) ? exp_lsu.size() > 0 : exp_csr.size() > 0;
		assert (ok) else begin
			$display("Queue %0d holds a record that the model never dispatched", cls);
			fail_run();
		end
		case (cls)
			0: begin
				model = exp_alu.pop_front();
				got = alu_info;
				name = "alu_info";
				alu_pop = 1'b1;
			end
			1: begin
				model = exp_bru.pop_front();
				got = bru_info;
				name = "bru_info";
				bru_pop = 1'b1;
			end
			2: begin
				model = exp_lsu.pop_front();
				got = rec_w'(lsu_info);
				name = "lsu_info";
				lsu_pop = 1'b1;
			end
			default: begin
				model = exp_csr.pop_front();
				got = rec_w'(csr_info);
				name = "csr_info";
				csr_pop = 1'b1;
			end
		endcase
		check_value("file record", make_record(cls, f[0][op_w-1:0], f[1], f[2],
			f[3][tag_w-1:0], f[4][tag_w-1:0], f[5][tag_w-1:0]), model);
		check_value(name, got, model);
		step();
		{alu_pop, bru_pop, lsu_pop, csr_pop} = '0;
	endtask

	task automatic commit(input logic [31:0] f [6]);
		logic [rob_info_w-1:0] model;
		logic [tag_w-1:0] tag;
		while (!rob_valid)
			step();
		assert (exp_rob.size() > 0) else begin
			$display("Reorder queue holds a record that the model never dispatched");
			fail_run();
		end
		model = exp_rob.pop_front();
		tag = model[rob_tag_pos +: tag_w];
		check_value("file commit", rec_w'({f[0], f[1][tag_w-1:0]}),
			rec_w'({model[rob_info_w-1 -: xlen_w], tag}));
		check_value("rob_info", rec_w'(rob_info), rec_w'(model));
		rob_pop = 1'b1;
		if (model[rob_wr_pos]) begin
			used[tag[tag_w-1 -: areg_w]][arch[tag[tag_w-1 -: areg_w]]] = 1'b0;
			arch[tag[tag_w-1 -: areg_w]] = tag[rb_w-1:0];
		end
		drain();
		step();
		rob_pop = 1'b0;
	endtask

	initial begin
		int fd;
		string line;
		logic [31:0] f [6];
		void'($urandom(80811));
		for (int r = 0; r < areg_n; r++) begin
			used[r] = rb'(1);
			active[r] = '0;
			arch[r] = '0;
		end
		fd = $fopen("dv/dispatch_tests.txt", "r");
		assert (fd != 0) else begin
			$display("Cannot open the command file");
			fail_run();
		end
		while ($fgets(line, fd))
			if (line.len() > 1 && line.getc(0) != "#")
				lines.push_back(line);
		$fclose(fd);
		limit_cycles = lines.size() * 40 + 20;
		repeat (8) @(posedge CLK);
		#1;
		reset = 1'b0;
		foreach (lines[i]) begin
			for (int k = 0; k < 6; k++)
				f[k] = '0;
			void'($sscanf(lines[i].substr(2, lines[i].len() - 1), "%h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5]));
			repeat ($urandom_range(3, 0))
				step();
			case (lines[i].getc(0))
				"P": push_uop(f);
				"A": pop_queue(0, f);
				"B": pop_queue(1, f);
				"L": pop_queue(2, f);
				"C": pop_queue(3, f);
				"R": commit(f);
				"W": repeat (f[0]) step();
				"F": check_value("uop_full", rec_w'(uop_full), rec_w'(f[0][0]));
				"E": begin
					check_value("valid levels", rec_w'({alu_valid, bru_valid, lsu_valid,
						csr_valid, rob_valid}), '0);
					check_value("model backlog", rec_w'(pend.size() + exp_rob.size()), '0);
				end
				default: begin
					$display("Unknown command in line: %s", lines[i]);
					fail_run();
				end
			endcase
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

	// Watchdog sized from the number of command lines.
	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles + 8) @(posedge CLK);
		$display("Timeout: the command file did not finish in %0d cycles", limit_cycles);
		fail_run();
	end

endmodule

//--- rtl/dispatch_top.sv
// Dispatch stage top: instruction queue, dispatch, rename, rename state,
// four issue queues and the reorder queue. Popping the reorder head commits.
`timescale 1ns/1ps

module dispatch_top (
	input  logic                                CLK,
	input  logic                                reset,
	input  logic                                uop_push,
	input  logic [dispatch_pkg::uop_w-1:0]      uop,
	output logic                                uop_full,
	output logic                                alu_valid,
	output logic [dispatch_pkg::alu_info_w-1:0] alu_info,
	input  logic                                alu_pop,
	output logic                                bru_valid,
	output logic [dispatch_pkg::bru_info_w-1:0] bru_info,
	input  logic                                bru_pop,
	output logic                                lsu_valid,
	output logic [dispatch_pkg::lsu_info_w-1:0] lsu_info,
	input  logic                                lsu_pop,
	output logic                                csr_valid,
	output logic [dispatch_pkg::csr_info_w-1:0] csr_info,
	input  logic                                csr_pop,
	output logic                                rob_valid,
	output logic [dispatch_pkg::rob_info_w-1:0] rob_info,
	input  logic                                rob_pop
);

	import dispatch_pkg::*;

	logic [uop_w-1:0] head_uop;
	logic head_empty, instr_pop;
	logic [areg_w-1:0] rs1, rs2, rd;
	logic rd_alloc, rd_runout;
	logic [tag_w-1:0] rs1_tag, rs2_tag, rd_tag;
	logic alloc_en;
	logic [areg_w-1:0] alloc_reg;
	logic [rb_w-1:0] alloc_idx;
	logic [areg_n-1:0][rb-1:0] copy_used;
	logic [areg_n-1:0][rb_w-1:0] copy_active;
	logic alu_push, bru_push, lsu_push, csr_push, rob_push;
	logic [alu_info_w-1:0] alu_wdata;
	logic [bru_info_w-1:0] bru_wdata;
	logic [lsu_info_w-1:0] lsu_wdata;
	logic [csr_info_w-1:0] csr_wdata;
	logic [rob_info_w-1:0] rob_wdata;
	logic alu_full, bru_full, lsu_full, csr_full, rob_full;
	logic alu_empty, bru_empty, lsu_empty, csr_empty, rob_empty;
	logic commit_en;

	sync_fifo #(.depth(instr_depth), .width(uop_w)) instr_q (
		.CLK(CLK), .reset(reset), .push(uop_push), .wdata(uop), .pop(instr_pop),
		.rdata(head_uop), .full(uop_full), .empty(head_empty));

	dispatch dispatch_i (
		.head_uop(head_uop), .head_empty(head_empty), .instr_pop(instr_pop),
		.rs1(rs1), .rs2(rs2), .rd(rd), .rd_alloc(rd_alloc),
		.rs1_tag(rs1_tag), .rs2_tag(rs2_tag), .rd_tag(rd_tag), .rd_runout(rd_runout),
		.alu_push(alu_push), .alu_info(alu_wdata), .alu_full(alu_full),
		.bru_push(bru_push), .bru_info(bru_wdata), .bru_full(bru_full),
		.lsu_push(lsu_push), .lsu_info(lsu_wdata), .lsu_full(lsu_full),
		.csr_push(csr_push), .csr_info(csr_wdata), .csr_full(csr_full),
		.rob_push(rob_push), .rob_info(rob_wdata), .rob_full(rob_full));

	rename rename_i (
		.rs1(rs1), .rs2(rs2), .rd(rd), .rd_alloc(rd_alloc),
		.copy_used(copy_used), .copy_active(copy_active),
		.rs1_tag(rs1_tag), .rs2_tag(rs2_tag), .rd_tag(rd_tag), .rd_runout(rd_runout),
		.alloc_en(alloc_en), .alloc_reg(alloc_reg), .alloc_idx(alloc_idx));

	// Commit takes the rd tag and written flag from the reorder head.
	assign commit_en = rob_pop & rob_valid;

	rename_state rename_state_i (
		.CLK(CLK), .reset(reset),
		.alloc_en(alloc_en), .alloc_reg(alloc_reg), .alloc_idx(alloc_idx),
		.commit_en(commit_en), .commit_tag(rob_info[rob_tag_pos +: tag_w]),
		.commit_wr(rob_info[rob_wr_pos]),
		.copy_used(copy_used), .copy_active(copy_active));

	sync_fifo #(.depth(iq_depth), .width(alu_info_w)) alu_q (
		.CLK(CLK), .reset(reset), .push(alu_push), .wdata(alu_wdata), .pop(alu_pop),
		.rdata(alu_info), .full(alu_full), .empty(alu_empty));

	sync_fifo #(.depth(iq_depth), .width(bru_info_w)) bru_q (
		.CLK(CLK), .reset(reset), .push(bru_push), .wdata(bru_wdata), .pop(bru_pop),
		.rdata(bru_info), .full(bru_full), .empty(bru_empty));

	sync_fifo #(.depth(iq_depth), .width(lsu_info_w)) lsu_q (
		.CLK(CLK), .reset(reset), .push(lsu_push), .wdata(lsu_wdata), .pop(lsu_pop),
		.rdata(lsu_info), .full(lsu_full), .empty(lsu_empty));

	sync_fifo #(.depth(iq_depth), .width(csr_info_w)) csr_q (
		.CLK(CLK), .reset(reset), .push(csr_push), .wdata(csr_wdata), .pop(csr_pop),
		.rdata(csr_info), .full(csr_full), .empty(csr_empty));

	sync_fifo #(.depth(rob_depth), .width(rob_info_w)) rob_q (
		.CLK(CLK), .reset(reset), .push(rob_push), .wdata(rob_wdata), .pop(rob_pop),
		.rdata(rob_info), .full(rob_full), .empty(rob_empty));

	assign alu_valid = ~alu_empty;
	assign bru_valid = ~bru_empty;
	assign lsu_valid = ~lsu_empty;
	assign csr_valid = ~csr_empty;
	assign rob_valid = ~rob_empty;

endmodule

//--- rtl/dispatch.sv
// In-order dispatch of the instruction queue head into its issue queue and
// the reorder queue, with stall on any full queue or rename run-out.
`timescale 1ns/1ps

module dispatch (
	input  logic [dispatch_pkg::uop_w-1:0]      head_uop,
	input  logic                                head_empty,
	output logic                                instr_pop,
	output logic [dispatch_pkg::areg_w-1:0]     rs1,
	output logic [dispatch_pkg::areg_w-1:0]     rs2,
	output logic [dispatch_pkg::areg_w-1:0]     rd,
	output logic                                rd_alloc,
	input  logic [dispatch_pkg::tag_w-1:0]      rs1_tag,
	input  logic [dispatch_pkg::tag_w-1:0]      rs2_tag,
	input  logic [dispatch_pkg::tag_w-1:0]      rd_tag,
	input  logic                                rd_runout,
	output logic                                alu_push,
	output logic [dispatch_pkg::alu_info_w-1:0] alu_info,
	input  logic                                alu_full,
	output logic                                bru_push,
	output logic [dispatch_pkg::bru_info_w-1:0] bru_info,
	input  logic                                bru_full,
	output logic                                lsu_push,
	output logic [dispatch_pkg::lsu_info_w-1:0] lsu_info,
	input  logic                                lsu_full,
	output logic                                csr_push,
	output logic [dispatch_pkg::csr_info_w-1:0] csr_info,
	input  logic                                csr_full,
	output logic                                rob_push,
	output logic [dispatch_pkg::rob_info_w-1:0] rob_info,
	input  logic                                rob_full
);

	import dispatch_pkg::*;

	uop_e op;
	logic [xlen_w-1:0] pc;
	logic [xlen_w-1:0] imm;
	logic [areg_w-1:0] uop_rd;
	logic [areg_w-1:0] uop_rs1;
	logic [areg_w-1:0] uop_rs2;
	logic is_alu, is_bru, is_lsu, is_csr;
	logic is_branch, is_store, is_unimpl, writes_rd;
	logic target_ok;
	logic go;

	assign op = uop_e'(head_uop[uop_w-1 -: op_w]);
	assign {pc, imm, uop_rd, uop_rs1, uop_rs2} = head_uop[uop_w-op_w-1:0];

	always_comb begin
		is_alu = 1'b0;
		is_bru = 1'b0;
		is_lsu = 1'b0;
		is_csr = 1'b0;
		is_branch = 1'b0;
		is_store = 1'b0;
		is_unimpl = 1'b0;
		writes_rd = 1'b0;
		case (op)
			op_lui, op_auipc, op_addi, op_addiw, op_add, op_addw, op_sub, op_subw,
			op_slti, op_sltiu, op_slt, op_sltu, op_xori, op_ori, op_andi,
			op_xor, op_or, op_and, op_slli, op_slliw, op_sll, op_sllw,
			op_srli, op_srliw, op_srl, op_srlw, op_srai, op_sraiw, op_sra, op_sraw: begin
				is_alu = 1'b1;
				writes_rd = 1'b1;
			end
			op_jal, op_jalr: begin
				is_bru = 1'b1;
				writes_rd = 1'b1;
			end
			op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
				is_bru = 1'b1;
				is_branch = 1'b1;
			end
			op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu: begin
				is_lsu = 1'b1;
				writes_rd = 1'b1;
			end
			op_sb, op_sh, op_sw, op_sd: begin
				is_lsu = 1'b1;
				is_store = 1'b1;
			end
			op_fence, op_fence_i:
				is_lsu = 1'b1;
			op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci: begin
				is_csr = 1'b1;
				writes_rd = 1'b1;
			end
			// mret, ebreak and undefined codes are dropped.
			default:
				is_unimpl = 1'b1;
		endcase
	end

	// Non-writing ops rename as x0 so they never allocate or run out.
	assign rs1 = uop_rs1;
	assign rs2 = uop_rs2;
	assign rd = writes_rd ? uop_rd : '0;

	assign target_ok = (is_alu & ~alu_full) | (is_bru & ~bru_full)
		| (is_lsu & ~lsu_full) | (is_csr & ~csr_full);
	assign go = ~head_empty & ~rob_full & ~rd_runout & target_ok;

	assign alu_push = go & is_alu;
	assign bru_push = go & is_bru;
	assign lsu_push = go & is_lsu;
	assign csr_push = go & is_csr;
	assign rob_push = go;
	assign rd_alloc = go & writes_rd;
	assign instr_pop = go | (~head_empty & is_unimpl);

	assign alu_info = {op, pc, imm, rd_tag, rs1_tag, rs2_tag};
	assign bru_info = {op, pc, imm, rd_tag, rs1_tag, rs2_tag};
	assign lsu_info = {op, imm, rd_tag, rs1_tag, rs2_tag};
	assign csr_info = {op, pc, imm[11:0], rd_tag, rs1_tag};
	assign rob_info = {pc, rd_tag, (rd != '0), is_branch, is_store, is_csr};

endmodule

//--- rtl/rename.sv
// Combinational register rename: source tags from the active copy and
// lowest free copy for the destination, with run-out detection.
`timescale 1ns/1ps

module rename (
	input  logic [dispatch_pkg::areg_w-1:0]                         rs1,
	input  logic [dispatch_pkg::areg_w-1:0]                         rs2,
	input  logic [dispatch_pkg::areg_w-1:0]                         rd,
	input  logic                                                    rd_alloc,
	input  logic [dispatch_pkg::areg_n-1:0][dispatch_pkg::rb-1:0]   copy_used,
	input  logic [dispatch_pkg::areg_n-1:0][dispatch_pkg::rb_w-1:0] copy_active,
	output logic [dispatch_pkg::tag_w-1:0]                          rs1_tag,
	output logic [dispatch_pkg::tag_w-1:0]                          rs2_tag,
	output logic [dispatch_pkg::tag_w-1:0]                          rd_tag,
	output logic                                                    rd_runout,
	output logic                                                    alloc_en,
	output logic [dispatch_pkg::areg_w-1:0]                         alloc_reg,
	output logic [dispatch_pkg::rb_w-1:0]                           alloc_idx
);

	import dispatch_pkg::*;

	logic [rb-1:0] rd_used;
	logic [rb_w-1:0] free_idx;
	logic rd_nonzero;

	// Register x0 never moves off copy 0, so its tag is always zero.
	assign rs1_tag = {rs1, copy_active[rs1]};
	assign rs2_tag = {rs2, copy_active[rs2]};

	assign rd_used = copy_used[rd];
	assign rd_nonzero = (rd != '0);

	// Lowest copy not in use.
	always_comb begin
		free_idx = '0;
		for (int i = rb - 1; i >= 0; i--) begin
			if (!rd_used[i])
				free_idx = rb_w'(i);
		end
	end

	assign rd_runout = rd_nonzero & (&rd_used);
	assign rd_tag = rd_nonzero ? {rd, free_idx} : '0;

	assign alloc_en = rd_alloc & rd_nonzero;
	assign alloc_reg = rd;
	assign alloc_idx = free_idx;

endmodule

//--- rtl/rename_state.sv
// Rename bookkeeping per architectural register: used copies, active copy
// and architectural copy. Written by rename at dispatch and by commit.
`timescale 1ns/1ps

module rename_state (
	input  logic                                                CLK,
	input  logic                                                reset,
	input  logic                                                alloc_en,
	input  logic [dispatch_pkg::areg_w-1:0]                     alloc_reg,
	input  logic [dispatch_pkg::rb_w-1:0]                       alloc_idx,
	input  logic                                                commit_en,
	input  logic [dispatch_pkg::tag_w-1:0]                      commit_tag,
	input  logic                                                commit_wr,
	output logic [dispatch_pkg::areg_n-1:0][dispatch_pkg::rb-1:0]   copy_used,
	output logic [dispatch_pkg::areg_n-1:0][dispatch_pkg::rb_w-1:0] copy_active
);

	import dispatch_pkg::*;

	logic [areg_n-1:0][rb_w-1:0] copy_arch;
	logic [areg_w-1:0] commit_reg;
	logic [rb_w-1:0] commit_idx;

	assign commit_reg = commit_tag[tag_w-1 -: areg_w];
	assign commit_idx = commit_tag[rb_w-1:0];

	always_ff @(posedge CLK) begin
		if (reset) begin
			// Copy 0 of every register starts in use and committed.
			for (int r = 0; r < areg_n; r++) begin
				copy_used[r] <= rb'(1);
				copy_active[r] <= '0;
				copy_arch[r] <= '0;
			end
		end else begin
			if (alloc_en) begin
				copy_used[alloc_reg][alloc_idx] <= 1'b1;
				copy_active[alloc_reg] <= alloc_idx;
			end
			// The freed copy is never the one being allocated.
			if (commit_en && commit_wr) begin
				copy_used[commit_reg][copy_arch[commit_reg]] <= 1'b0;
				copy_arch[commit_reg] <= commit_idx;
			end
		end
	end

endmodule

//--- rtl/sync_fifo.sv
// Synchronous FIFO with full and empty levels and the head on rdata.
// Used for the instruction, issue and reorder queues.
`timescale 1ns/1ps

module sync_fifo #(
	parameter int depth = 4,
	parameter int width = 8
) (
	input  logic             CLK,
	input  logic             reset,
	input  logic             push,
	input  logic [width-1:0] wdata,
	input  logic             pop,
	output logic [width-1:0] rdata,
	output logic             full,
	output logic             empty
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	logic [width-1:0] mem [depth];
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [cnt_w-1:0] count;
	logic do_push;
	logic do_pop;

	// Push when full and pop when empty are ignored.
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + ptr_w'(1);
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + ptr_w'(1);
			count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
		end
	end

	assign rdata = mem[rd_ptr];
	assign full = (count == cnt_w'(depth));
	assign empty = (count == '0);

endmodule

//--- rtl/dispatch_pkg.sv
// Shared widths, micro-op opcodes and record layouts for the dispatch stage.
// Imported by every RTL block and by the testbench.
package dispatch_pkg;

	localparam int xlen_w = 32;
	localparam int areg_w = 5;
	localparam int areg_n = 1 << areg_w;

	// Rename copies per architectural register.
	localparam int rb = 4;
	localparam int rb_w = 2;

	// Tag is {register index, copy index}.
	localparam int tag_w = areg_w + rb_w;

	localparam int op_w = 6;

	typedef enum logic [op_w-1:0] {
		// ALU class.
		op_lui, op_auipc,
		op_addi, op_addiw, op_add, op_addw, op_sub, op_subw,
		op_slti, op_sltiu, op_slt, op_sltu,
		op_xori, op_ori, op_andi, op_xor, op_or, op_and,
		op_slli, op_slliw, op_sll, op_sllw,
		op_srli, op_srliw, op_srl, op_srlw,
		op_srai, op_sraiw, op_sra, op_sraw,
		// Branch class.
		op_jal, op_jalr, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
		// Load/store class.
		op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
		op_sb, op_sh, op_sw, op_sd,
		op_fence, op_fence_i,
		// CSR class.
		op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci,
		// Not implemented, dropped at dispatch.
		op_mret, op_ebreak
	} uop_e;

	// Micro-op layout is {op, pc, imm, rd, rs1, rs2}.
	localparam int uop_w = op_w + 2 * xlen_w + 3 * areg_w;

	// Issue records.
	localparam int alu_info_w = op_w + 2 * xlen_w + 3 * tag_w;
	localparam int bru_info_w = op_w + 2 * xlen_w + 3 * tag_w;
	localparam int lsu_info_w = op_w + xlen_w + 3 * tag_w;
	localparam int csr_info_w = op_w + xlen_w + 12 + 2 * tag_w;

	// Reorder record is {pc, rd tag, rd written, is_branch, is_store, is_csr}.
	localparam int rob_info_w = xlen_w + tag_w + 4;
	localparam int rob_wr_pos = 3;
	localparam int rob_tag_pos = 4;

	localparam int instr_depth = 8;
	localparam int iq_depth = 4;
	localparam int rob_depth = 8;

endpackage
